//--- board_seeder.sv
//////////////////////////////
// LFSR board seeding
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module board_seeder import life_pkg::*, ctrl_pkg::*; (
	input  logic    clk4,
	input  logic    reset,
	output row_wr_t seed_wr,   // Row writes into bank 0
	output logic    seed_done  // High once board is full
);

	logic [31:0] lfsr;
	delay_cnt_t  delay_cnt;   // Startup wait
	logic        filling;     // LFSR stepping
	logic [$clog2(GRID_W)-1:0] col_cnt;
	row_idx_t    row_cnt;
	row_t        row_sr;      // Cells shift in from the top, col 0 ends in bit 0
	logic        wr_we;
	row_idx_t    wr_row;
	row_t        wr_data;
	logic        last_col;

	assign last_col = (col_cnt == GRID_W-1);

	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr      <= LFSR_SEED;
			delay_cnt <= '0;
			filling   <= 1'b0;
			col_cnt   <= '0;
			row_cnt   <= '0;
			wr_we     <= 1'b0;
			seed_done <= 1'b0;
		end else begin
			if (delay_cnt != delay_cnt_t'(SEED_DELAY))
				delay_cnt <= delay_cnt + 1'b1;
			if (delay_cnt == delay_cnt_t'(SEED_DELAY-1))
				filling <= 1'b1; // Only hit once after reset
			else if (filling && last_col && row_cnt == row_idx_t'(GRID_H-1))
				filling <= 1'b0;
			if (filling) begin
				// Fibonacci taps 31 21 1 0, shift right
				lfsr    <= {lfsr[0] ^ lfsr[1] ^ lfsr[21] ^ lfsr[31], lfsr[31:1]};
				col_cnt <= col_cnt + 1'b1; // Wraps at GRID_W
				if (last_col)
					row_cnt <= row_cnt + 1'b1;
			end
			wr_we     <= filling && last_col;
			seed_done <= seed_done || (wr_we && wr_row == row_idx_t'(GRID_H-1));
		end
	end

	// Row payload
	always_ff @(posedge clk4) begin
		if (filling) begin
			row_sr <= {lfsr[0], row_sr[GRID_W-1:1]};
		end
		if (filling && last_col) begin
			wr_row  <= row_cnt;
			wr_data <= {lfsr[0], row_sr[GRID_W-1:1]}; // Last cell joins here
		end
	end

	assign seed_wr = {wr_we, wr_row, wr_data};

endmodule

`default_nettype wire

//--- button_debounce.sv
//////////////////////////////
// Fire button debounce
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module button_debounce import ctrl_pkg::*; (
	input  logic clk4,
	input  logic reset,
	input  logic fire_button, // Raw async button
	output logic short_fire,  // One shot after PRESS_TICKS
	output logic long_fire    // Held level until released
);

	logic [2:0] meta;    // Synchronizer chain
	logic       inm;     // Synchronized button
	deb_state_t state;
	press_cnt_t press_cnt;
	rel_cnt_t   rel_cnt;
	logic       press_hit;
	logic       long_hit;
	logic       rel_hit;

	// Three flop synchronizer
	always_ff @(posedge clk4) begin
		if (reset)
			meta <= '0;
		else
			meta <= {meta[1:0], fire_button};
	end
	assign inm = meta[2];

	assign press_hit = (press_cnt == press_cnt_t'(PRESS_TICKS-1));
	assign long_hit  = (press_cnt == press_cnt_t'(LONG_TICKS-1));
	assign rel_hit   = !inm && (rel_cnt == rel_cnt_t'(RELEASE_TICKS-1));

	//////////////////////////////
	// State machine
	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:       state <= inm ? S_WAIT_PRESS : S_IDLE;
				S_WAIT_PRESS: state <= !inm ? S_IDLE : press_hit ? S_WAIT_LONG : S_WAIT_PRESS;
				S_WAIT_LONG:  state <= !inm ? S_WAIT_OFF : long_hit ? S_LONG : S_WAIT_LONG;
				S_LONG:       state <= !inm ? S_WAIT_LOFF : S_LONG;
				S_WAIT_OFF:   state <= inm ? S_WAIT_LONG : rel_hit ? S_IDLE : S_WAIT_OFF;
				S_WAIT_LOFF:  state <= inm ? S_LONG : rel_hit ? S_IDLE : S_WAIT_LOFF;
				default:      state <= S_IDLE;
			endcase
		end
	end

	// Press time counts from first high and saturates at long
	// Release time counts only while low in the off states
	always_ff @(posedge clk4) begin
		if (reset) begin
			press_cnt <= '0;
			rel_cnt   <= '0;
		end else begin
			if (state == S_IDLE)
				press_cnt <= '0;
			else if (!long_hit)
				press_cnt <= press_cnt + 1'b1;
			if ((state == S_WAIT_OFF || state == S_WAIT_LOFF) && !inm)
				rel_cnt <= rel_cnt + 1'b1;
			else
				rel_cnt <= '0; // Any bounce high restarts release
		end
	end

	// Pulse on the accepting cycle only
	assign short_fire = (state == S_WAIT_PRESS) && inm && press_hit;
	assign long_fire  = (state == S_LONG) || (state == S_WAIT_LOFF);

	// One shot only after a full press time and never during a long hold
	a_fire_excl: assert property (@(posedge clk4) disable iff (reset)
		short_fire |-> !long_fire && $past(inm, PRESS_TICKS));

endmodule

`default_nettype wire

//--- ctrl_pkg.sv
//////////////////////////////
// Control timing and states
//////////////////////////////
`default_nettype none

package ctrl_pkg;

	// Debounce times, scaled down for simulation
	localparam int PRESS_TICKS   = 8;    // High time before press accepted
	localparam int LONG_TICKS    = 200;  // Hold time for long press
	localparam int RELEASE_TICKS = 16;   // Low time to end a press

	// Seeding and rate timing
	localparam int SEED_DELAY       = 20;    // Idle cycles after reset
	localparam int TICKS_PER_SECOND = 1000;  // Simulated second
	localparam logic [31:0] LFSR_SEED = 32'h5a3c_96e1; // Any non zero

	// Counter widths
	typedef logic [$clog2(LONG_TICKS+1)-1:0]  press_cnt_t;
	typedef logic [$clog2(RELEASE_TICKS)-1:0] rel_cnt_t;
	typedef logic [$clog2(SEED_DELAY+1)-1:0]  delay_cnt_t;
	typedef logic [$clog2(TICKS_PER_SECOND)-1:0] sec_cnt_t;

	// Debounce FSM
	typedef enum logic [2:0] {
		S_IDLE, S_WAIT_PRESS, S_WAIT_LONG, S_LONG, S_WAIT_OFF, S_WAIT_LOFF
	} deb_state_t;

	// Generation sequencer FSM
	typedef enum logic [1:0] {
		SQ_SEED, SQ_IDLE, SQ_RUN
	} seq_state_t;

endpackage

`default_nettype wire

//--- gen_counters.sv
//////////////////////////////
// Generation counters
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module gen_counters import life_pkg::*, ctrl_pkg::*; (
	input  logic     clk4,
	input  logic     reset,
	input  logic     gen_done,   // One per generation
	output gen_cnt_t gen_count,  // Total
	output gen_cnt_t gen_rate    // Per second, last window
);

	sec_cnt_t sec_cnt;
	logic     sec_tick;    // One cycle per simulated second
	gen_cnt_t window_cnt;  // Generations in current second

	// Second divider
	always_ff @(posedge clk4) begin
		if (reset) begin
			sec_cnt  <= '0;
			sec_tick <= 1'b0;
		end else begin
			sec_cnt  <= (sec_cnt == sec_cnt_t'(TICKS_PER_SECOND-1)) ? '0 : sec_cnt + 1'b1;
			sec_tick <= (sec_cnt == sec_cnt_t'(TICKS_PER_SECOND-1));
		end
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_count  <= '0;
			gen_rate   <= '0;
			window_cnt <= '0;
		end else begin
			if (gen_done)
				gen_count <= gen_count + 1'b1;
			if (sec_tick) begin
				gen_rate   <= window_cnt;
				window_cnt <= gen_done ? gen_cnt_t'(1) : '0; // Tick cycle pulse opens new window
			end else if (gen_done) begin
				window_cnt <= window_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- gen_sequencer.sv
//////////////////////////////
// Generation sequencer
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module gen_sequencer import life_pkg::*, ctrl_pkg::*; (
	input  logic     clk4,
	input  logic     reset,
	input  logic     short_fire,   // One generation
	input  logic     long_fire,    // Back to back while held
	input  logic     seed_done,    // Board ready
	input  logic     gen_done,     // Last row written
	output row_cmd_t row_cmd,      // Row compute commands
	output logic     bank,         // Displayed bank
	output logic     seeding_busy,
	output logic     running
);

	seq_state_t state;
	logic       go;
	logic       cmd_stb;
	row_idx_t   row_cnt;
	logic       last_row;

	assign go       = short_fire || long_fire;
	assign last_row = (row_cnt == row_idx_t'(GRID_H-1));

	//////////////////////////////
	// Main FSM
	always_ff @(posedge clk4) begin
		if (reset) begin
			state   <= SQ_SEED;
			cmd_stb <= 1'b0;
			row_cnt <= '0;
			bank    <= 1'b0;
		end else begin
			case (state)
				SQ_SEED: begin
					// Hold off presses until the board exists
					if (seed_done)
						state <= SQ_IDLE;
				end
				SQ_IDLE: begin
					if (go) begin
						state   <= SQ_RUN;
						cmd_stb <= 1'b1;
						row_cnt <= '0;
					end
				end
				SQ_RUN: begin
					// One command per cycle for a whole board
					if (cmd_stb) begin
						if (last_row)
							cmd_stb <= 1'b0;
						else
							row_cnt <= row_cnt + 1'b1;
					end
					// Drain done, new board now on display
					if (gen_done) begin
						bank <= !bank;
						if (go) begin
							cmd_stb <= 1'b1; // Straight into next generation
							row_cnt <= '0;
						end else begin
							state <= SQ_IDLE;
						end
					end
				end
				default: begin
					state   <= SQ_IDLE;
					cmd_stb <= 1'b0;
				end
			endcase
		end
	end

	// Status
	assign running      = (state == SQ_RUN);
	assign seeding_busy = (state == SQ_SEED);

	assign row_cmd = {cmd_stb, row_cnt};

	// Engine never computes over a half seeded board
	a_cmd_after_seed: assert property (@(posedge clk4) disable iff (reset)
		row_cmd.stb |-> seed_done);

endmodule

`default_nettype wire

//--- life_pkg.sv
//////////////////////////////
// Life board types
//////////////////////////////
`default_nettype none

package life_pkg;

	// Board geometry
	localparam int GRID_W   = 16;  // Cells per row
	localparam int GRID_H   = 12;  // Rows per board
	localparam int ROW_BITS = 4;   // Row index width

	typedef logic [GRID_W-1:0]   row_t;     // One board row, col 0 in bit 0
	typedef logic [ROW_BITS-1:0] row_idx_t; // Row address
	typedef logic [31:0]         gen_cnt_t; // Generation counts

	// Read port request
	typedef struct packed {
		logic     stb;
		row_idx_t row;
	} rd_req_t;

	// Read port response, 2 cycles after request
	typedef struct packed {
		logic valid;
		row_t data;
	} rd_rsp_t;

	// Compute command, one row per cycle
	typedef struct packed {
		logic     stb;
		row_idx_t row;
	} row_cmd_t;

	// Seed write into bank 0
	typedef struct packed {
		logic     we;
		row_idx_t row;
		row_t     data;
	} row_wr_t;

endpackage

`default_nettype wire

//--- life_row_engine.sv
//////////////////////////////
// Life row engine
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module life_row_engine import life_pkg::*; (
	input  logic     clk4,
	input  logic     reset,
	input  row_cmd_t row_cmd,  // Row to compute
	input  logic     bank,     // Displayed bank, read side
	input  row_wr_t  seed_wr,  // Initial board
	input  rd_req_t  rd_req,
	output rd_rsp_t  rd_rsp,
	output logic     gen_done  // Pulse after last row write
);

	row_t     mem [2][GRID_H];   // Ping pong banks
	row_idx_t up_idx, dn_idx;    // Wrapped neighbours
	logic     c_valid;           // Stage 1 compute
	row_idx_t c_row;
	logic     c_bank;            // Bank to write
	row_t     n_up, n_mid, n_dn;
	row_t     next_row;
	logic     r_stb;             // Stage 1 read
	row_idx_t r_row;
	logic     r_bank;
	logic     rsp_valid;
	row_t     rsp_data;

	// Toroidal life rule over one row
	function automatic row_t life_next(input row_t up, input row_t mid, input row_t dn);
		row_t       res;
		logic [3:0] cnt;
		row_t       up_w, up_e, mid_w, mid_e, dn_w, dn_e;
		up_w  = {up[GRID_W-2:0], up[GRID_W-1]};   // Col i sees i-1
		up_e  = {up[0], up[GRID_W-1:1]};          // Col i sees i+1
		mid_w = {mid[GRID_W-2:0], mid[GRID_W-1]};
		mid_e = {mid[0], mid[GRID_W-1:1]};
		dn_w  = {dn[GRID_W-2:0], dn[GRID_W-1]};
		dn_e  = {dn[0], dn[GRID_W-1:1]};
		for (int i = 0; i < GRID_W; i++) begin
			cnt = 4'(up_w[i]) + 4'(up[i]) + 4'(up_e[i]) + 4'(mid_w[i]) + 4'(mid_e[i])
				+ 4'(dn_w[i]) + 4'(dn[i]) + 4'(dn_e[i]);
			res[i] = (cnt == 4'd3) || (mid[i] && cnt == 4'd2); // Birth or survive
		end
		return res;
	endfunction

	assign up_idx   = (row_cmd.row == '0) ? row_idx_t'(GRID_H-1) : row_cmd.row - 1'b1;
	assign dn_idx   = (row_cmd.row == row_idx_t'(GRID_H-1)) ? '0 : row_cmd.row + 1'b1;
	assign next_row = life_next(n_up, n_mid, n_dn);

	//////////////////////////////
	// Control pipeline
	always_ff @(posedge clk4) begin
		if (reset) begin
			c_valid   <= 1'b0;
			gen_done  <= 1'b0;
			r_stb     <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			c_valid   <= row_cmd.stb;
			gen_done  <= c_valid && c_row == row_idx_t'(GRID_H-1);
			r_stb     <= rd_req.stb;
			rsp_valid <= r_stb;
		end
	end

	// Datapath and banks
	always_ff @(posedge clk4) begin
		c_row  <= row_cmd.row;
		c_bank <= !bank;              // Result goes to hidden bank
		n_up   <= mem[bank][up_idx];
		n_mid  <= mem[bank][row_cmd.row];
		n_dn   <= mem[bank][dn_idx];
		if (seed_wr.we)
			mem[0][seed_wr.row] <= seed_wr.data;
		else if (c_valid)
			mem[c_bank][c_row] <= next_row;
		r_row    <= rd_req.row;
		r_bank   <= bank;             // Bank at request time
		rsp_data <= mem[r_bank][r_row];
	end

	assign rd_rsp = {rsp_valid, rsp_data};

	// Seeding finishes before any compute starts
	a_wr_excl: assert property (@(posedge clk4) disable iff (reset)
		!(seed_wr.we && row_cmd.stb));

endmodule

`default_nettype wire

//--- life_top.sv
//////////////////////////////
// Game of Life top
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module life_top import life_pkg::*; (
	input  logic     clk4,
	input  logic     reset,
	input  logic     fire_button,
	input  rd_req_t  rd_req,        // Row read port
	output rd_rsp_t  rd_rsp,
	output logic     seeding_busy,
	output logic     running,
	output gen_cnt_t gen_count,
	output gen_cnt_t gen_rate
);

	logic     short_fire;
	logic     long_fire;
	row_wr_t  seed_wr;
	logic     seed_done;
	row_cmd_t row_cmd;
	logic     bank;
	logic     gen_done;

	//////////////////////////////
	// Control
	button_debounce u_debounce (
		.clk4        (clk4),
		.reset       (reset),
		.fire_button (fire_button),
		.short_fire  (short_fire),
		.long_fire   (long_fire)
	);

	board_seeder u_seeder (
		.clk4      (clk4),
		.reset     (reset),
		.seed_wr   (seed_wr),
		.seed_done (seed_done)
	);

	gen_sequencer u_sequencer (
		.clk4         (clk4),
		.reset        (reset),
		.short_fire   (short_fire),
		.long_fire    (long_fire),
		.seed_done    (seed_done),
		.gen_done     (gen_done),
		.row_cmd      (row_cmd),
		.bank         (bank),
		.seeding_busy (seeding_busy),
		.running      (running)
	);

	//////////////////////////////
	// Engine and stats
	life_row_engine u_engine (
		.clk4     (clk4),
		.reset    (reset),
		.row_cmd  (row_cmd),
		.bank     (bank),
		.seed_wr  (seed_wr),
		.rd_req   (rd_req),
		.rd_rsp   (rd_rsp),
		.gen_done (gen_done)
	);

	gen_counters u_counters (
		.clk4      (clk4),
		.reset     (reset),
		.gen_done  (gen_done),
		.gen_count (gen_count),
		.gen_rate  (gen_rate)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the life testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_life -Mdir obj_dir -o tb_life
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_life > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "No result line in $LOG"
	exit 1
fi
exit 0

//--- tb_life.sv
//////////////////////////////
// Life engine testbench
//////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_life import life_pkg::*, ctrl_pkg::*; ();

	typedef logic [GRID_H-1:0][GRID_W-1:0] board_t; // Row r in board[r]

	logic     clk4 = 1'b0;
	logic     reset;
	logic     fire_button;
	rd_req_t  rd_req;
	rd_rsp_t  rd_rsp;
	logic     seeding_busy;
	logic     running;
	gen_cnt_t gen_count;
	gen_cnt_t gen_rate;

	int unsigned cyc = 0;     // Cycle number
	int unsigned req_q[$];    // Cycles of sampled requests
	row_t        exp_q[$];    // Expected rows in request order
	int          errors = 0;
	int          reads = 0;
	gen_cnt_t    rate_max;    // Peak rate seen while holding
	board_t      model;       // Reference board

	life_top dut_i (
		.clk4         (clk4),
		.reset        (reset),
		.fire_button  (fire_button),
		.rd_req       (rd_req),
		.rd_rsp       (rd_rsp),
		.seeding_busy (seeding_busy),
		.running      (running),
		.gen_count    (gen_count),
		.gen_rate     (gen_rate)
	);

	always #20 clk4 = ~clk4; // 40 ns period

	//////////////////////////////
	// Reference model

	// One toroidal generation
	function automatic board_t life_step(input board_t b);
		board_t n;
		int     cnt;
		int     rr;
		int     cc;
		for (int r = 0; r < GRID_H; r++) begin
			for (int c = 0; c < GRID_W; c++) begin
				cnt = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + GRID_H) % GRID_H; // Wrap rows
						cc = (c + dc + GRID_W) % GRID_W; // Wrap columns
						if (dr != 0 || dc != 0)
							cnt += int'(b[rr][cc]);
					end
				end
				n[r][c] = (cnt == 3) || (b[r][c] && cnt == 2);
			end
		end
		return n;
	endfunction

	// Board filled by the LFSR in column then row order
	function automatic board_t seed_board(input logic [31:0] seed);
		board_t      b;
		logic [31:0] s;
		logic        fb;
		s = seed;
		for (int r = 0; r < GRID_H; r++) begin
			for (int c = 0; c < GRID_W; c++) begin
				b[r][c] = s[0];
				fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 31 21 1 0
				s  = (s >> 1) | (32'(fb) << 31);
			end
		end
		return b;
	endfunction

	task automatic log_mismatch(input string msg);
		$display("FAILED %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0d ns while waiting for %s", $time, what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	//////////////////////////////
	// Read response checker
	always @(posedge clk4) begin : compare
		int unsigned t;
		row_t        exp;
		cyc <= cyc + 1;
		if (rd_rsp.valid === 1'b1) begin
			if (req_q.size() == 0) begin
				log_mismatch("read response without a request");
			end else begin
				t   = req_q.pop_front();
				exp = exp_q.pop_front();
				if (cyc - t != 2)
					log_mismatch($sformatf("read latency %0d cycles, expected 2", cyc - t));
				if (rd_rsp.data !== exp)
					log_mismatch($sformatf("row data %h, expected %h", rd_rsp.data, exp));
			end
		end else if (req_q.size() != 0 && cyc - req_q[0] >= 2) begin
			log_mismatch("read request got no response after 2 cycles");
			void'(req_q.pop_front());
			void'(exp_q.pop_front());
		end
		if (rd_req.stb === 1'b1)
			req_q.push_back(cyc); // Request cycle
	end

	//////////////////////////////
	// Stimulus tasks
	task automatic read_rows(input board_t exp, input int first, input int count);
		for (int r = first; r < first + count; r++) begin
			@(posedge clk4);
			rd_req <= '{stb: 1'b1, row: row_idx_t'(r)};
			exp_q.push_back(exp[r]);
			reads++;
		end
		@(posedge clk4);
		rd_req <= '{stb: 1'b0, row: '0};
	endtask

	task automatic wait_reads_done();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk4);
			n++;
			if (n > 20)
				stop_on_timeout("read responses");
		end
	endtask

	task automatic wait_seed_end(input int limit);
		int n;
		n = 0;
		while (seeding_busy !== 1'b0) begin
			@(posedge clk4);
			n++;
			if (n > limit)
				stop_on_timeout("end of seeding");
		end
	endtask

	task automatic wait_running(input logic level, input int limit);
		int n;
		n = 0;
		while (running !== level) begin
			@(posedge clk4);
			n++;
			if (n > limit)
				stop_on_timeout(level ? "run start" : "run end");
		end
	endtask

	task automatic wait_count(input gen_cnt_t target, input int limit);
		int n;
		n = 0;
		while (gen_count < target) begin
			@(posedge clk4);
			n++;
			if (n > limit)
				stop_on_timeout("generation count");
		end
	endtask

	// Hold the button for len cycles and track the peak rate
	task automatic hold_button(input int len);
		@(posedge clk4);
		fire_button <= 1'b1;
		for (int i = 0; i < len; i++) begin
			@(posedge clk4);
			if (gen_rate > rate_max)
				rate_max = gen_rate;
		end
		fire_button <= 1'b0;
	endtask

	task automatic check_board();
		read_rows(model, 0, GRID_H);
		wait_reads_done();
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	//////////////////////////////
	// Main sequence
	initial begin
		int unsigned seed_val;
		int unsigned len;
		gen_cnt_t    start_cnt;
		gen_cnt_t    n_gen;
		int          err0;
		reset       = 1'b1;
		fire_button = 1'b0;
		rd_req      = '0;
		rate_max    = '0;
		seed_val    = $urandom(32'heabd_baf5); // Seeds this process
		repeat (2) @(posedge clk4);
		reset <= 1'b0;

		// Reset values and seeded board
		err0 = errors;
		@(posedge clk4);
		if (rd_rsp.valid !== 1'b0 || running !== 1'b0 || seeding_busy !== 1'b1
			|| gen_count !== '0 || gen_rate !== '0)
			log_mismatch("outputs not idle after reset");
		wait_seed_end(1000);
		model = seed_board(LFSR_SEED);
		check_board();
		report_test("1 reset and seeding", err0);

		// Short press for one generation
		err0      = errors;
		start_cnt = gen_count;
		len       = PRESS_TICKS + 2 + $urandom % (LONG_TICKS - PRESS_TICKS - 21);
		hold_button(len);
		wait_count(start_cnt + 1, 200);
		wait_running(1'b0, 100);
		repeat (RELEASE_TICKS + 16) @(posedge clk4); // Debounce back to idle
		if (gen_count != start_cnt + 1)
			log_mismatch($sformatf("short press gave %0d generations", gen_count - start_cnt));
		model = life_step(model);
		check_board();
		report_test("2 short press", err0);

		// Long hold over many generations
		err0      = errors;
		start_cnt = gen_count;
		len       = LONG_TICKS + 101 + $urandom % 300;
		hold_button(len);
		wait_running(1'b0, 500);
		repeat (RELEASE_TICKS + 16) @(posedge clk4);
		n_gen = gen_count - start_cnt;
		if (n_gen <= 1)
			log_mismatch($sformatf("long hold gave %0d generations", n_gen));
		for (int i = 0; i < int'(n_gen); i++)
			model = life_step(model);
		check_board();
		report_test("3 long hold", err0);

		// Reads during a run see the previous board
		err0      = errors;
		start_cnt = gen_count;
		len       = PRESS_TICKS + 2 + $urandom % (LONG_TICKS - PRESS_TICKS - 21);
		fork
			hold_button(len);
			begin
				wait_running(1'b1, 300);
				read_rows(model, 0, 6); // Well inside one generation
			end
		join
		wait_reads_done();
		wait_count(start_cnt + 1, 200);
		wait_running(1'b0, 100);
		repeat (RELEASE_TICKS + 16) @(posedge clk4);
		if (gen_count != start_cnt + 1)
			log_mismatch($sformatf("short press gave %0d generations", gen_count - start_cnt));
		model = life_step(model);
		check_board();
		report_test("4 read latency and reads during run", err0);

		// Rate over a multi second hold and the idle after it
		err0      = errors;
		start_cnt = gen_count;
		rate_max  = '0;
		len       = 2 * TICKS_PER_SECOND + 100 + $urandom % 400;
		hold_button(len);
		if (rate_max == 0 || rate_max > TICKS_PER_SECOND / GRID_H)
			log_mismatch($sformatf("peak rate %0d during hold, limit %0d",
				rate_max, TICKS_PER_SECOND / GRID_H));
		wait_running(1'b0, 500);
		repeat (RELEASE_TICKS + 16) @(posedge clk4);
		n_gen = gen_count - start_cnt;
		for (int i = 0; i < int'(n_gen); i++)
			model = life_step(model);
		check_board();
		repeat (2 * TICKS_PER_SECOND + 100) @(posedge clk4); // Two idle seconds
		if (gen_rate != 0)
			log_mismatch($sformatf("rate %0d after idle seconds, expected 0", gen_rate));
		report_test("5 generation rate", err0);

		$display("tests 5, reads %0d, errors %0d", reads, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
life_pkg.sv
ctrl_pkg.sv
button_debounce.sv
board_seeder.sv
gen_sequencer.sv
life_row_engine.sv
gen_counters.sv
life_top.sv
tb_life.sv
